/* button_conditioner.sv */
`timescale 1ns/1ps
`include "memory_game_cfg.svh"

module button_conditioner (
    input  logic clk,
    input  logic rst,
    input  logic btn_i,
    output logic pulse_o
);

    localparam int CNT_W = $clog2(`MG_DEBOUNCE_LEN + 1);

    logic [CNT_W-1:0] stable_cnt;
    logic             at_max;
    logic             reached;

    assign at_max = (stable_cnt == CNT_W'(`MG_DEBOUNCE_LEN));

    // This sample completes the stable window
    assign reached = btn_i && (stable_cnt == CNT_W'(`MG_DEBOUNCE_LEN - 1));

    // Saturating count of consecutive high samples
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stable_cnt <= '0;
        end else if (!btn_i) begin
            stable_cnt <= '0;
        end else if (!at_max) begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // Fires once per press since a held button stays at max
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pulse_o <= 1'b0;
        end else begin
            pulse_o <= reached;
        end
    end

endmodule

/* card_board.sv */
`timescale 1ns/1ps
`include "memory_game_cfg.svh"

module card_board
    import memory_game_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  board_cmd_e board_cmd_i,
    input  logic       play_en_i,
    input  logic       hint_i,
    input  logic       enter_i,
    input  logic       flip_i,
    input  card_idx_t  flip_card_i,
    input  logic       pair_i,
    input  card_idx_t  pair_a_i,
    input  card_idx_t  pair_b_i,
    output card_mask_t shown_o,
    output card_mask_t matched_o,
    output card_mask_t flipped_o,
    output logic       ready_o,
    output logic       pass_o,
    output logic       finish_req_o
);

    card_mask_t  shown_q;
    card_mask_t  matched_q;
    card_mask_t  flipped_q;
    pair_count_t pair_cnt;
    logic        ready_q;
    logic        pass_q;

    logic        act_en;
    logic        do_enter;
    logic        do_flip;
    logic        do_pair;
    logic        same_image;
    logic        pair_hit;
    logic        all_found;

    // Hint blocks every play action
    assign act_en = play_en_i && !hint_i;

    // Enter only matters once a turn has been played
    assign do_enter = act_en && enter_i && !ready_q;
    assign do_flip  = act_en && flip_i && ready_q && !matched_q[flip_card_i];
    assign do_pair  = act_en && pair_i && ready_q
                      && !matched_q[pair_a_i] && !matched_q[pair_b_i];

    // Card i shows image i mod 8
    assign same_image = (pair_a_i % card_idx_t'(`MG_NUM_PAIRS))
                        == (pair_b_i % card_idx_t'(`MG_NUM_PAIRS));

    // Upside-down cards never match
    assign pair_hit  = same_image && !flipped_q[pair_a_i] && !flipped_q[pair_b_i];
    assign all_found = (pair_cnt == pair_count_t'(`MG_NUM_PAIRS));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shown_q      <= '0;
            matched_q    <= '0;
            flipped_q    <= '0;
            pair_cnt     <= '0;
            ready_q      <= 1'b1;
            pass_q       <= 1'b0;
            finish_req_o <= 1'b0;
        end else begin
            finish_req_o <= 1'b0;
            case (board_cmd_i)
                CMD_CLEAR: begin
                    shown_q   <= '0;
                    matched_q <= '0;
                    flipped_q <= '0;
                    pair_cnt  <= '0;
                    ready_q   <= 1'b1;
                    pass_q    <= 1'b0;
                end
                CMD_DEAL: begin
                    shown_q   <= '1;
                    matched_q <= '0;
                    flipped_q <= `MG_FLIP_PRESET;
                    pair_cnt  <= '0;
                    ready_q   <= 1'b1;
                end
                CMD_HIDE: begin
                    shown_q <= '0;
                end
                CMD_REVEAL: begin
                    shown_q   <= '1;
                    matched_q <= '1;
                    pass_q    <= 1'b1;
                end
                default: begin
                    if (do_enter) begin
                        // Turn the cards of the last turn face down again
                        shown_q <= '0;
                        ready_q <= 1'b1;
                        if (all_found) begin
                            finish_req_o <= 1'b1;
                        end
                    end else if (do_flip) begin
                        shown_q[flip_card_i]   <= 1'b1;
                        flipped_q[flip_card_i] <= ~flipped_q[flip_card_i];
                        ready_q                <= 1'b0;
                    end else if (do_pair) begin
                        shown_q[pair_a_i] <= 1'b1;
                        shown_q[pair_b_i] <= 1'b1;
                        ready_q           <= 1'b0;
                        if (pair_hit) begin
                            matched_q[pair_a_i] <= 1'b1;
                            matched_q[pair_b_i] <= 1'b1;
                            pair_cnt            <= pair_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    assign shown_o   = shown_q;
    assign matched_o = matched_q;
    assign flipped_o = flipped_q;
    assign ready_o   = ready_q;
    assign pass_o    = pass_q;

endmodule

/* compile.f */
+incdir+.
memory_game_pkg.sv
button_conditioner.sv
key_tracker.sv
game_fsm.sv
card_board.sv
memory_game_top.sv
tb_clock_gen.sv
tb_memory_game.sv

/* game_fsm.sv */
`timescale 1ns/1ps

module game_fsm
    import memory_game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start_pulse_i,
    input  logic        finish_req_i,
    output game_state_e state_o,
    output logic        play_en_o,
    output board_cmd_e  board_cmd_o
);

    game_state_e state_q;
    game_state_e state_d;
    board_cmd_e  cmd_d;

    always_comb begin
        state_d = state_q;
        cmd_d   = CMD_NONE;
        case (state_q)
            INIT: begin
                if (start_pulse_i) begin
                    state_d = SHOW;
                    cmd_d   = CMD_DEAL;
                end
            end
            SHOW: begin
                if (start_pulse_i) begin
                    state_d = GAME;
                    cmd_d   = CMD_HIDE;
                end
            end
            // Start button has no effect during play
            GAME: begin
                if (finish_req_i) begin
                    state_d = FINISH;
                    cmd_d   = CMD_REVEAL;
                end
            end
            FINISH: begin
                if (start_pulse_i) begin
                    state_d = INIT;
                    cmd_d   = CMD_CLEAR;
                end
            end
            default: begin
                state_d = INIT;
                cmd_d   = CMD_CLEAR;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= INIT;
            board_cmd_o <= CMD_NONE;
        end else begin
            state_q     <= state_d;
            board_cmd_o <= cmd_d;
        end
    end

    assign state_o   = state_q;
    assign play_en_o = (state_q == GAME);

endmodule

/* game_input.txt */
# Commands: B long press, S short press, H level, M code (make), R code (break), P random game
# E state shown matched flipped ready pass, all hex, checked 4 cycles after the previous command
E 0 0000 0000 0000 1 0
B
E 1 ffff 0000 6003 1 0
S
E 1 ffff 0000 6003 1 0
B
E 2 0000 0000 6003 1 0
B
E 2 0000 0000 6003 1 0
# Hint blocks a matching pair on cards 2 and 10
H 1
M 026
M 023
R 023
R 026
E 2 0000 0000 6003 1 0
H 0
M 026
M 023
R 023
R 026
E 2 0404 0404 6003 0 0
M 05A
R 05A
E 2 0000 0404 6003 1 0
P
E 3 ffff ffff 0000 1 1
B
E 0 0000 0000 0000 1 0

/* key_tracker.sv */
`timescale 1ns/1ps
`include "memory_game_cfg.svh"

module key_tracker
    import memory_game_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       key_valid_i,
    input  scan_code_t key_code_i,
    input  logic       key_make_i,
    output logic       enter_o,
    output logic       flip_o,
    output card_idx_t  flip_card_o,
    output logic       pair_o,
    output card_idx_t  pair_a_o,
    output card_idx_t  pair_b_o
);

    scan_code_t partner_code;
    logic       partner_held;
    card_idx_t  new_card;
    card_idx_t  old_card;
    logic       new_is_card;
    logic       old_is_card;
    logic       is_make;
    logic       chord;
    logic       shift_flip_old;
    logic       shift_flip_new;
    logic       two_cards;

    function automatic card_idx_t card_lookup(input scan_code_t code, output logic hit);
        hit = 1'b1;
        case (code)
            `MG_SCAN_CARD0:  card_lookup = card_idx_t'(0);
            `MG_SCAN_CARD1:  card_lookup = card_idx_t'(1);
            `MG_SCAN_CARD2:  card_lookup = card_idx_t'(2);
            `MG_SCAN_CARD3:  card_lookup = card_idx_t'(3);
            `MG_SCAN_CARD4:  card_lookup = card_idx_t'(4);
            `MG_SCAN_CARD5:  card_lookup = card_idx_t'(5);
            `MG_SCAN_CARD6:  card_lookup = card_idx_t'(6);
            `MG_SCAN_CARD7:  card_lookup = card_idx_t'(7);
            `MG_SCAN_CARD8:  card_lookup = card_idx_t'(8);
            `MG_SCAN_CARD9:  card_lookup = card_idx_t'(9);
            `MG_SCAN_CARD10: card_lookup = card_idx_t'(10);
            `MG_SCAN_CARD11: card_lookup = card_idx_t'(11);
            `MG_SCAN_CARD12: card_lookup = card_idx_t'(12);
            `MG_SCAN_CARD13: card_lookup = card_idx_t'(13);
            `MG_SCAN_CARD14: card_lookup = card_idx_t'(14);
            `MG_SCAN_CARD15: card_lookup = card_idx_t'(15);
            default: begin
                hit         = 1'b0;
                card_lookup = '0;
            end
        endcase
    endfunction

    always_comb begin
        new_card = card_lookup(key_code_i, new_is_card);
        old_card = card_lookup(partner_code, old_is_card);
    end

    assign is_make = key_valid_i && key_make_i;
    // Second key pressed while the first is still down
    assign chord   = is_make && partner_held && (key_code_i != partner_code);

    assign shift_flip_old = (key_code_i == `MG_SCAN_LSHIFT) && old_is_card;
    assign shift_flip_new = (partner_code == `MG_SCAN_LSHIFT) && new_is_card;
    assign two_cards      = old_is_card && new_is_card;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            partner_code <= '0;
            partner_held <= 1'b0;
            enter_o      <= 1'b0;
            flip_o       <= 1'b0;
            pair_o       <= 1'b0;
        end else begin
            if (is_make) begin
                partner_code <= key_code_i;
                partner_held <= 1'b1;
            end else if (key_valid_i && key_code_i == partner_code) begin
                partner_held <= 1'b0;
            end
            enter_o <= is_make && (key_code_i == `MG_SCAN_ENTER);
            flip_o  <= chord && (shift_flip_old || shift_flip_new);
            pair_o  <= chord && !shift_flip_old && !shift_flip_new && two_cards;
        end
    end

    // Card numbers ride along with the strobes
    always_ff @(posedge clk) begin
        flip_card_o <= shift_flip_old ? old_card : new_card;
        pair_a_o    <= old_card;
        pair_b_o    <= new_card;
    end

endmodule

/* memory_game_cfg.svh */
`ifndef MEMORY_GAME_CFG_SVH
`define MEMORY_GAME_CFG_SVH

// Board geometry
`define MG_NUM_CARDS      16
`define MG_NUM_PAIRS      8

`define MG_SCAN_W         9
`define MG_DEBOUNCE_LEN   7

`define MG_SCAN_ENTER     9'h05A
`define MG_SCAN_LSHIFT    9'h012

// Cards 0, 1, 13 and 14 are dealt upside down
`define MG_FLIP_PRESET    16'h6003

// Key rows 1234 / QWER / ASDF / ZXCV
`define MG_SCAN_CARD0     9'h016
`define MG_SCAN_CARD1     9'h01E
`define MG_SCAN_CARD2     9'h026
`define MG_SCAN_CARD3     9'h025
`define MG_SCAN_CARD4     9'h015
`define MG_SCAN_CARD5     9'h01D
`define MG_SCAN_CARD6     9'h024
`define MG_SCAN_CARD7     9'h02D
`define MG_SCAN_CARD8     9'h01C
`define MG_SCAN_CARD9     9'h01B
`define MG_SCAN_CARD10    9'h023
`define MG_SCAN_CARD11    9'h02B
`define MG_SCAN_CARD12    9'h01A
`define MG_SCAN_CARD13    9'h022
`define MG_SCAN_CARD14    9'h021
`define MG_SCAN_CARD15    9'h02A

`endif

/* memory_game_pkg.sv */
`include "memory_game_cfg.svh"

package memory_game_pkg;

    // Card number on the 4x4 board
    typedef logic [$clog2(`MG_NUM_CARDS)-1:0] card_idx_t;

    // One bit per card
    typedef logic [`MG_NUM_CARDS-1:0] card_mask_t;

    typedef logic [`MG_SCAN_W-1:0] scan_code_t;

    // Matched pairs from zero up to the full count
    typedef logic [$clog2(`MG_NUM_PAIRS+1)-1:0] pair_count_t;

    typedef enum logic [1:0] {
        INIT   = 2'd0,
        SHOW   = 2'd1,
        GAME   = 2'd2,
        FINISH = 2'd3
    } game_state_e;

    typedef enum logic [2:0] {
        CMD_NONE   = 3'd0,
        CMD_CLEAR  = 3'd1,
        CMD_DEAL   = 3'd2,
        CMD_HIDE   = 3'd3,
        CMD_REVEAL = 3'd4
    } board_cmd_e;

endpackage

/* memory_game_top.sv */
`timescale 1ns/1ps

module memory_game_top
    import memory_game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start_i,
    input  logic        hint_i,
    input  logic        key_valid_i,
    input  scan_code_t  key_code_i,
    input  logic        key_make_i,
    output game_state_e state_o,
    output card_mask_t  shown_o,
    output card_mask_t  matched_o,
    output card_mask_t  flipped_o,
    output logic        ready_o,
    output logic        pass_o
);

    logic       start_pulse;
    logic       enter_evt;
    logic       flip_evt;
    card_idx_t  flip_card;
    logic       pair_evt;
    card_idx_t  pair_a;
    card_idx_t  pair_b;
    logic       finish_req;
    logic       play_en;
    board_cmd_e board_cmd;

    button_conditioner button_conditioner_i (
        .clk     (clk),
        .rst     (rst),
        .btn_i   (start_i),
        .pulse_o (start_pulse)
    );

    key_tracker key_tracker_i (
        .clk         (clk),
        .rst         (rst),
        .key_valid_i (key_valid_i),
        .key_code_i  (key_code_i),
        .key_make_i  (key_make_i),
        .enter_o     (enter_evt),
        .flip_o      (flip_evt),
        .flip_card_o (flip_card),
        .pair_o      (pair_evt),
        .pair_a_o    (pair_a),
        .pair_b_o    (pair_b)
    );

    game_fsm game_fsm_i (
        .clk           (clk),
        .rst           (rst),
        .start_pulse_i (start_pulse),
        .finish_req_i  (finish_req),
        .state_o       (state_o),
        .play_en_o     (play_en),
        .board_cmd_o   (board_cmd)
    );

    card_board card_board_i (
        .clk          (clk),
        .rst          (rst),
        .board_cmd_i  (board_cmd),
        .play_en_i    (play_en),
        .hint_i       (hint_i),
        .enter_i      (enter_evt),
        .flip_i       (flip_evt),
        .flip_card_i  (flip_card),
        .pair_i       (pair_evt),
        .pair_a_i     (pair_a),
        .pair_b_i     (pair_b),
        .shown_o      (shown_o),
        .matched_o    (matched_o),
        .flipped_o    (flipped_o),
        .ready_o      (ready_o),
        .pass_o       (pass_o),
        .finish_req_o (finish_req)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f compile.f --top-module tb_memory_game -o sim_memory_game \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_memory_game > sim.log 2>&1 || echo "Simulator returned a failing status"
cat sim.log

grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset held over the first three rising edges
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        #1 rst_o = 1'b0;
    end

endmodule

/* tb_memory_game.sv */
`timescale 1ns/1ps
`include "memory_game_cfg.svh"

module tb_memory_game
    import memory_game_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        start;
    logic        hint;
    logic        key_valid;
    scan_code_t  key_code;
    logic        key_make;
    game_state_e state;
    card_mask_t  shown;
    card_mask_t  matched;
    card_mask_t  flipped;
    logic        ready;
    logic        passed;

    // Reference model of the board
    card_mask_t  m_shown;
    card_mask_t  m_matched;
    card_mask_t  m_flipped;
    logic        m_ready;
    int          m_pairs;

    scan_code_t  card_code [`MG_NUM_CARDS];
    integer      seed;
    int          check_count;
    int          fd;

    tb_clock_gen tb_clock_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    memory_game_top memory_game_top_i (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start),
        .hint_i      (hint),
        .key_valid_i (key_valid),
        .key_code_i  (key_code),
        .key_make_i  (key_make),
        .state_o     (state),
        .shown_o     (shown),
        .matched_o   (matched),
        .flipped_o   (flipped),
        .ready_o     (ready),
        .pass_o      (passed)
    );

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_state(input game_state_e got, input game_state_e exp, input string name);
        check_count++;
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_mask(input card_mask_t got, input card_mask_t exp, input string name);
        check_count++;
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %04h expected %04h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        check_count++;
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %0b expected %0b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Advance to 1 ns after the next rising edge
    task automatic step(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        @(posedge clk);
        while (rst && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst) begin
            $display("Error: reset was never released");
            abort_run();
        end
        #1;
    endtask

    task automatic wait_state(input game_state_e exp, input int limit);
        int n;
        n = 0;
        while (state != exp && n < limit) begin
            step(1);
            n++;
        end
        if (state != exp) begin
            $display("Error: timed out waiting for state %s", exp.name());
            abort_run();
        end
    endtask

    task automatic key_event(input scan_code_t code, input logic make);
        key_valid = 1'b1;
        key_code  = code;
        key_make  = make;
        step(1);
        key_valid = 1'b0;
        step(1);
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'($unsigned(r) % n);
    endfunction

    function automatic void model_pair(input card_idx_t a, input card_idx_t b);
        if (m_ready && !m_matched[a] && !m_matched[b]) begin
            m_shown[a] = 1'b1;
            m_shown[b] = 1'b1;
            m_ready    = 1'b0;
            // Same image and both face up
            if ((int'(a) % `MG_NUM_PAIRS) == (int'(b) % `MG_NUM_PAIRS)
                    && !m_flipped[a] && !m_flipped[b]) begin
                m_matched[a] = 1'b1;
                m_matched[b] = 1'b1;
                m_pairs++;
            end
        end
    endfunction

    function automatic void model_flip(input card_idx_t c);
        if (m_ready && !m_matched[c]) begin
            m_shown[c]   = 1'b1;
            m_flipped[c] = ~m_flipped[c];
            m_ready      = 1'b0;
        end
    endfunction

    task automatic check_model();
        check_state(state, GAME, "state_o");
        check_mask(shown, m_shown, "shown_o");
        check_mask(matched, m_matched, "matched_o");
        check_mask(flipped, m_flipped, "flipped_o");
        check_bit(ready, m_ready, "ready_o");
    endtask

    task automatic play_pair(input card_idx_t a, input card_idx_t b, input logic blocked);
        key_event(card_code[a], 1'b1);
        key_event(card_code[b], 1'b1);
        key_event(card_code[b], 1'b0);
        key_event(card_code[a], 1'b0);
        if (!blocked) begin
            model_pair(a, b);
        end
        step(2);
        check_model();
    endtask

    task automatic play_flip(input card_idx_t c, input logic shift_first, input logic blocked);
        if (shift_first) begin
            key_event(`MG_SCAN_LSHIFT, 1'b1);
            key_event(card_code[c], 1'b1);
            key_event(card_code[c], 1'b0);
            key_event(`MG_SCAN_LSHIFT, 1'b0);
        end else begin
            key_event(card_code[c], 1'b1);
            key_event(`MG_SCAN_LSHIFT, 1'b1);
            key_event(`MG_SCAN_LSHIFT, 1'b0);
            key_event(card_code[c], 1'b0);
        end
        if (!blocked) begin
            model_flip(c);
        end
        step(2);
        check_model();
    endtask

    task automatic play_enter();
        key_event(`MG_SCAN_ENTER, 1'b1);
        key_event(`MG_SCAN_ENTER, 1'b0);
        if (!m_ready) begin
            m_shown = '0;
            m_ready = 1'b1;
        end
        step(2);
        check_model();
    endtask

    // Random turns until all pairs are found and Enter ends the game
    task automatic play_game();
        int         actions;
        int         sel;
        int         k;
        card_idx_t  a;
        card_idx_t  b;
        actions = 0;
        hint    = 1'b0;
        step(1);
        while (m_pairs < `MG_NUM_PAIRS && actions < 600) begin
            actions++;
            a = card_idx_t'(rand_below(`MG_NUM_CARDS));
            b = card_idx_t'((int'(a) + 1 + rand_below(`MG_NUM_CARDS - 1)) % `MG_NUM_CARDS);
            if (!m_ready) begin
                // Board is locked until Enter
                if (rand_below(2) == 0) begin
                    play_pair(a, b, 1'b0);
                end
                play_enter();
            end else begin
                sel = rand_below(8);
                if (sel < 2) begin
                    play_pair(a, b, 1'b0);
                end else if (sel == 2) begin
                    play_flip(a, rand_below(2) == 0, 1'b0);
                end else if (sel == 3) begin
                    hint = 1'b1;
                    step(1);
                    if (rand_below(2) == 0) begin
                        play_pair(a, b, 1'b1);
                    end else begin
                        play_flip(a, rand_below(2) == 0, 1'b1);
                    end
                    hint = 1'b0;
                    step(1);
                end else begin
                    k = 0;
                    while (m_matched[a] && k < `MG_NUM_CARDS) begin
                        a = card_idx_t'((int'(a) + 1) % `MG_NUM_CARDS);
                        k++;
                    end
                    b = a ^ card_idx_t'(`MG_NUM_PAIRS);
                    if (m_flipped[a] || m_flipped[b]) begin
                        // Same image but one card is face down
                        play_pair(a, b, 1'b0);
                        play_enter();
                        if (m_flipped[a]) begin
                            play_flip(a, rand_below(2) == 0, 1'b0);
                        end else begin
                            play_flip(b, rand_below(2) == 0, 1'b0);
                        end
                    end else if (rand_below(2) == 0) begin
                        play_pair(a, b, 1'b0);
                    end else begin
                        play_pair(b, a, 1'b0);
                    end
                end
            end
        end
        if (m_pairs < `MG_NUM_PAIRS) begin
            $display("Error: game not finished after %0d actions", actions);
            abort_run();
        end
        key_event(`MG_SCAN_ENTER, 1'b1);
        key_event(`MG_SCAN_ENTER, 1'b0);
        wait_state(FINISH, 20);
    endtask

    task automatic next_command(output logic [7:0] cmd, output logic eof);
        int ch;
        ch  = $fgetc(fd);
        eof = 1'b0;
        cmd = 8'h20;
        while (ch != -1 && (8'(ch) == " " || 8'(ch) == "\n" || 8'(ch) == "\r"
                || 8'(ch) == "\t" || 8'(ch) == "#")) begin
            if (8'(ch) == "#") begin
                while (ch != -1 && 8'(ch) != "\n") begin
                    ch = $fgetc(fd);
                end
            end
            if (ch != -1) begin
                ch = $fgetc(fd);
            end
        end
        if (ch == -1) begin
            eof = 1'b1;
        end else begin
            cmd = 8'(ch);
        end
    endtask

    task automatic need_args(input int got, input int want, input logic [7:0] cmd);
        if (got != want) begin
            $display("Error: command %c in game_input.txt has %0d values, needs %0d",
                     cmd, got, want);
            abort_run();
        end
    endtask

    task automatic run_command(input logic [7:0] cmd);
        logic [31:0] v0;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] v4;
        logic [31:0] v5;
        int          n;
        case (cmd)
            "B": begin
                start = 1'b1;
                step(12);
                start = 1'b0;
                step(12);
            end
            "S": begin
                start = 1'b1;
                step(3);
                start = 1'b0;
                step(1);
            end
            "H": begin
                n = $fscanf(fd, "%h", v0);
                need_args(n, 1, cmd);
                hint = v0[0];
                step(1);
            end
            "M", "R": begin
                n = $fscanf(fd, "%h", v0);
                need_args(n, 1, cmd);
                key_event(scan_code_t'(v0), cmd == "M");
            end
            "P": play_game();
            "E": begin
                n = $fscanf(fd, "%h %h %h %h %h %h", v0, v1, v2, v3, v4, v5);
                need_args(n, 6, cmd);
                step(4);
                check_state(state, game_state_e'(v0[1:0]), "state_o");
                check_mask(shown, card_mask_t'(v1), "shown_o");
                check_mask(matched, card_mask_t'(v2), "matched_o");
                check_mask(flipped, card_mask_t'(v3), "flipped_o");
                check_bit(ready, v4[0], "ready_o");
                check_bit(passed, v5[0], "pass_o");
                // Model continues from the expected board
                m_shown   = card_mask_t'(v1);
                m_matched = card_mask_t'(v2);
                m_flipped = card_mask_t'(v3);
                m_ready   = v4[0];
                m_pairs   = $countones(card_mask_t'(v2)) / 2;
            end
            default: begin
                $display("Error: unknown command %c in game_input.txt", cmd);
                abort_run();
            end
        endcase
    endtask

    initial begin
        logic [7:0] cmd;
        logic       eof;
        start       = 1'b0;
        hint        = 1'b0;
        key_valid   = 1'b0;
        key_code    = '0;
        key_make    = 1'b0;
        seed        = 89748;
        check_count = 0;
        m_shown     = '0;
        m_matched   = '0;
        m_flipped   = '0;
        m_ready     = 1'b1;
        m_pairs     = 0;
        card_code   = '{`MG_SCAN_CARD0, `MG_SCAN_CARD1, `MG_SCAN_CARD2, `MG_SCAN_CARD3,
                        `MG_SCAN_CARD4, `MG_SCAN_CARD5, `MG_SCAN_CARD6, `MG_SCAN_CARD7,
                        `MG_SCAN_CARD8, `MG_SCAN_CARD9, `MG_SCAN_CARD10, `MG_SCAN_CARD11,
                        `MG_SCAN_CARD12, `MG_SCAN_CARD13, `MG_SCAN_CARD14, `MG_SCAN_CARD15};
        wait_reset_release();
        fd = $fopen("game_input.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open game_input.txt");
            abort_run();
        end
        next_command(cmd, eof);
        while (!eof) begin
            run_command(cmd);
            next_command(cmd, eof);
        end
        $fclose(fd);
        if (check_count == 0) begin
            $display("Error: no checks were run");
            abort_run();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule
